// ==== tb.f ====
+incdir+hw
hw/mips_ex_pkg.sv
hw/alu.sv
hw/forwarding_unit.sv
hw/instruction_execute.sv
hw/memory_access.sv
hw/execute_subsystem.sv
testbench/tb_execute_subsystem.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f tb.f --top-module tb_execute_subsystem -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_execute_subsystem.sv ====
`include "mips_ex_settings.svh"

module tb_execute_subsystem;

    // issued instructions per test, summed for the watchdog
    localparam int n_steps = 2 * (11 + 7) + 8 + (4 + 8 + 2 * 10) + 9 + 2;

    typedef struct packed {
        mips_ex_pkg::reg_idx_t rs;
        mips_ex_pkg::reg_idx_t rt;
        mips_ex_pkg::reg_idx_t rd;
        mips_ex_pkg::data_t    imm;
        logic [5:0]            opcode;
        logic [4:0]            shamt;
        logic [5:0]            func;
        mips_ex_pkg::ex_ctrl_t ctrl;
    } instr_t;

    logic                  clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_halt;
    mips_ex_pkg::reg_idx_t i_rs;
    mips_ex_pkg::reg_idx_t i_rt;
    mips_ex_pkg::reg_idx_t i_rd;
    mips_ex_pkg::data_t    i_reg_da;
    mips_ex_pkg::data_t    i_reg_db;
    mips_ex_pkg::data_t    i_immediate;
    logic [5:0]            i_opcode;
    logic [4:0]            i_shamt;
    logic [5:0]            i_func;
    mips_ex_pkg::ex_ctrl_t i_ctrl;
    mips_ex_pkg::mem_wb_t  o_mem_wb;

    // arch holds every executed result and rf only what has reached write-back
    mips_ex_pkg::data_t    arch [32];
    mips_ex_pkg::data_t    rf [32];
    mips_ex_pkg::data_t    mem_model [`MIPS_DMEM_WORDS];
    logic [5:0]            words [4];

    mips_ex_pkg::mem_wb_t  pe = '0;
    mips_ex_pkg::mem_wb_t  pw = '0;
    instr_t                cur = '0;
    logic                  cur_halt = 1'b0;
    logic [31:0]           rng_state = 32'd75999;
    int                    n_checks = 0;
    int                    n_errors = 0;

    execute_subsystem u_execute_subsystem (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_halt      (i_halt),
        .i_rs        (i_rs),
        .i_rt        (i_rt),
        .i_rd        (i_rd),
        .i_reg_da    (i_reg_da),
        .i_reg_db    (i_reg_db),
        .i_immediate (i_immediate),
        .i_opcode    (i_opcode),
        .i_shamt     (i_shamt),
        .i_func      (i_func),
        .i_ctrl      (i_ctrl),
        .o_mem_wb    (o_mem_wb)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic mips_ex_pkg::reg_idx_t rand_reg();
        return 5'(32'd1 + next_rand() % 32'd31);
    endfunction

    function automatic instr_t alu_instr(input mips_ex_pkg::alu_class_e cls,
                                         input logic [5:0] code,
                                         input mips_ex_pkg::reg_idx_t rs,
                                         input mips_ex_pkg::reg_idx_t rt,
                                         input mips_ex_pkg::reg_idx_t rd,
                                         input logic dst_rd);
        instr_t      ins;
        logic [31:0] r;
        ins = '0;
        r = next_rand();
        ins.rs = rs;
        ins.rt = rt;
        ins.rd = rd;
        ins.imm = next_rand();
        ins.shamt = r[4:0];
        if (cls == mips_ex_pkg::R_TYPE) begin
            ins.func = code;
        end else begin
            ins.opcode = code;
        end
        ins.ctrl.reg_write = 1'b1;
        ins.ctrl.reg_dst = dst_rd;
        ins.ctrl.imm_sel = (cls == mips_ex_pkg::I_TYPE);
        ins.ctrl.width = mips_ex_pkg::WORD;
        ins.ctrl.alu_class = cls;
        return ins;
    endfunction

    // address is r0 + immediate and rt is the data or destination register
    function automatic instr_t mem_instr(input logic store, input mips_ex_pkg::mem_width_e w,
                                         input logic sx, input logic [7:0] addr,
                                         input mips_ex_pkg::reg_idx_t r);
        instr_t ins;
        ins = '0;
        ins.rt = r;
        ins.imm = {24'h000000, addr};
        ins.ctrl.mem_write = store;
        ins.ctrl.mem_read = !store;
        ins.ctrl.mem_to_reg = !store;
        ins.ctrl.reg_write = !store;
        ins.ctrl.imm_sel = 1'b1;
        ins.ctrl.width = w;
        ins.ctrl.sign_ext = sx;
        ins.ctrl.alu_class = mips_ex_pkg::LOAD_STORE;
        return ins;
    endfunction

    function automatic instr_t bubble();
        instr_t ins;
        ins = '0;
        ins.ctrl.width = mips_ex_pkg::WORD;
        ins.ctrl.alu_class = mips_ex_pkg::BRANCH;
        return ins;
    endfunction

    // executes one instruction on the model in program order
    function automatic mips_ex_pkg::mem_wb_t predict(input instr_t ins);
        mips_ex_pkg::data_t   a;
        mips_ex_pkg::data_t   bf;
        mips_ex_pkg::data_t   b;
        mips_ex_pkg::data_t   res;
        mips_ex_pkg::data_t   word;
        mips_ex_pkg::data_t   ld;
        logic [7:0]           by;
        logic [15:0]          hw;
        logic [1:0]           ln;
        mips_ex_pkg::mem_wb_t wb;
        a = arch[ins.rs];
        bf = arch[ins.rt];
        b = ins.ctrl.imm_sel ? ins.imm : bf;
        res = '0;
        case (ins.ctrl.alu_class)
            mips_ex_pkg::LOAD_STORE: res = a + b;
            mips_ex_pkg::R_TYPE: begin
                case (ins.func)
                    6'h20: res = a + b;
                    6'h22: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2a: res = {31'd0, $signed(a) < $signed(b)};
                    6'h00: res = b << ins.shamt;
                    6'h02: res = b >> ins.shamt;
                    6'h03: res = $signed(b) >>> ins.shamt;
                    default: res = '0;
                endcase
            end
            mips_ex_pkg::I_TYPE: begin
                case (ins.opcode)
                    6'h08: res = a + b;
                    6'h0c: res = a & b;
                    6'h0d: res = a | b;
                    6'h0e: res = a ^ b;
                    6'h0a: res = {31'd0, $signed(a) < $signed(b)};
                    6'h0f: res = {b[15:0], 16'h0000};
                    default: res = '0;
                endcase
            end
            default: res = '0;
        endcase
        ln = res[1:0];
        word = mem_model[res[7:2]];
        if (ins.ctrl.mem_write) begin
            case (ins.ctrl.width)
                mips_ex_pkg::BYTE: word[8 * ln +: 8] = bf[7:0];
                mips_ex_pkg::HALF: word[16 * ln[1] +: 16] = bf[15:0];
                default: word = bf;
            endcase
            mem_model[res[7:2]] = word;
        end
        by = word[8 * ln +: 8];
        hw = word[16 * ln[1] +: 16];
        case (ins.ctrl.width)
            mips_ex_pkg::BYTE: ld = ins.ctrl.sign_ext ? {{24{by[7]}}, by} : {24'd0, by};
            mips_ex_pkg::HALF: ld = ins.ctrl.sign_ext ? {{16{hw[15]}}, hw} : {16'd0, hw};
            default: ld = word;
        endcase
        if (!ins.ctrl.mem_read) begin
            ld = '0;
        end
        wb.reg_write = ins.ctrl.reg_write;
        wb.write_reg = ins.ctrl.reg_dst ? ins.rd : ins.rt;
        wb.wb_data = ins.ctrl.mem_to_reg ? ld : res;
        if (wb.reg_write && (wb.write_reg != 5'd0)) begin
            arch[wb.write_reg] = wb.wb_data;
        end
        return wb;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail at time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_instr(input instr_t ins, input logic halt);
        i_rs <= ins.rs;
        i_rt <= ins.rt;
        i_rd <= ins.rd;
        i_reg_da <= rf[ins.rs];
        i_reg_db <= rf[ins.rt];
        i_immediate <= ins.imm;
        i_opcode <= ins.opcode;
        i_shamt <= ins.shamt;
        i_func <= ins.func;
        i_ctrl <= ins.ctrl;
        i_halt <= halt;
        cur = ins;
        cur_halt = halt;
    endtask

    // advances the model by one clock and checks write-back
    task automatic step(input instr_t ins, input logic halt);
        @(posedge clk);
        if (!cur_halt) begin
            pw = pe;
            pe = predict(cur);
        end
        drive_instr(ins, halt);
        @(negedge clk);
        check_value(64'(o_mem_wb), 64'(pw), "mem/wb record");
        if (pw.reg_write && (pw.write_reg != 5'd0)) begin
            rf[pw.write_reg] = pw.wb_data;
        end
    endtask

    task automatic reset_values();
        @(negedge clk);
        check_value(64'(o_mem_wb), 64'd0, "mem/wb after reset");
    endtask

    task automatic alu_results();
        logic [5:0]  r_codes [11];
        logic [5:0]  i_codes [7];
        logic [31:0] r;
        int          round;
        int          i;
        r_codes = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h00, 6'h02, 6'h03, 6'h3f};
        i_codes = '{6'h08, 6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0f, 6'h3f};
        for (round = 0; round < 2; round++) begin
            for (i = 0; i < 11; i++) begin
                r = next_rand();
                step(alu_instr(mips_ex_pkg::R_TYPE, r_codes[i], rand_reg(), rand_reg(),
                               rand_reg(), r[0]), 1'b0);
            end
            for (i = 0; i < 7; i++) begin
                r = next_rand();
                step(alu_instr(mips_ex_pkg::I_TYPE, i_codes[i], rand_reg(), rand_reg(),
                               rand_reg(), r[0]), 1'b0);
            end
        end
    endtask

    task automatic forwarding_paths();
        step(alu_instr(mips_ex_pkg::I_TYPE, 6'h08, 5'd0, 5'd5, 5'd0, 1'b0), 1'b0);
        // r5 from ex/mem on both operands
        step(alu_instr(mips_ex_pkg::R_TYPE, 6'h20, 5'd5, 5'd5, 5'd6, 1'b1), 1'b0);
        // r5 from mem/wb, r6 from ex/mem
        step(alu_instr(mips_ex_pkg::R_TYPE, 6'h26, 5'd5, 5'd6, 5'd7, 1'b1), 1'b0);
        // write to r0 must not be forwarded
        step(alu_instr(mips_ex_pkg::R_TYPE, 6'h20, 5'd6, 5'd7, 5'd0, 1'b1), 1'b0);
        step(alu_instr(mips_ex_pkg::R_TYPE, 6'h20, 5'd0, 5'd0, 5'd8, 1'b1), 1'b0);
        // r9 in both records and the newer one wins
        step(alu_instr(mips_ex_pkg::I_TYPE, 6'h08, 5'd0, 5'd9, 5'd0, 1'b0), 1'b0);
        step(alu_instr(mips_ex_pkg::I_TYPE, 6'h0d, 5'd7, 5'd9, 5'd0, 1'b0), 1'b0);
        step(alu_instr(mips_ex_pkg::R_TYPE, 6'h20, 5'd9, 5'd9, 5'd10, 1'b1), 1'b0);
    endtask

    task automatic load_store_lanes();
        logic [31:0]             r;
        logic [5:0]              w;
        mips_ex_pkg::mem_width_e wd;
        logic                    sx;
        int                      i;
        // whole words first so that every later lane is defined
        for (i = 0; i < 4; i++) begin
            words[i] = 6'(next_rand() % 32'd16) + 6'(i * 16);
            step(mem_instr(1'b1, mips_ex_pkg::WORD, 1'b0, {words[i], 2'b00}, rand_reg()), 1'b0);
        end
        for (i = 0; i < 8; i++) begin
            r = next_rand();
            w = words[r[3:2]];
            if (i % 2 == 1) begin
                step(mem_instr(1'b1, mips_ex_pkg::HALF, 1'b0, {w, r[1], 1'b0}, rand_reg()), 1'b0);
            end else begin
                step(mem_instr(1'b1, mips_ex_pkg::BYTE, 1'b0, {w, r[1:0]}, rand_reg()), 1'b0);
            end
        end
        for (i = 0; i < 10; i++) begin
            r = next_rand();
            w = words[r[3:2]];
            case (i % 5)
                0: begin
                    wd = mips_ex_pkg::BYTE;
                    sx = 1'b1;
                end
                1: begin
                    wd = mips_ex_pkg::BYTE;
                    sx = 1'b0;
                end
                2: begin
                    wd = mips_ex_pkg::HALF;
                    sx = 1'b1;
                end
                3: begin
                    wd = mips_ex_pkg::HALF;
                    sx = 1'b0;
                end
                default: begin
                    wd = mips_ex_pkg::WORD;
                    sx = 1'b0;
                end
            endcase
            step(mem_instr(1'b0, wd, sx, {w, r[1:0]}, 5'(20 + i % 4)), 1'b0);
            // load result is not forwarded from ex/mem
            step(bubble(), 1'b0);
        end
    endtask

    task automatic halt_hold();
        int i;
        step(alu_instr(mips_ex_pkg::R_TYPE, 6'h20, 5'd11, 5'd12, 5'd13, 1'b1), 1'b0);
        step(alu_instr(mips_ex_pkg::I_TYPE, 6'h0d, 5'd13, 5'd14, 5'd0, 1'b0), 1'b0);
        // a store seen only while halted is dropped and mem/wb holds its value
        for (i = 0; i < 4; i++) begin
            step(mem_instr(1'b1, mips_ex_pkg::WORD, 1'b0, {words[0], 2'b00}, 5'd15), 1'b1);
        end
        step(mem_instr(1'b0, mips_ex_pkg::WORD, 1'b0, {words[0], 2'b00}, 5'd21), 1'b0);
        step(bubble(), 1'b0);
        step(alu_instr(mips_ex_pkg::R_TYPE, 6'h26, 5'd13, 5'd14, 5'd16, 1'b1), 1'b0);
    endtask

    initial begin
        #(n_steps * 4 + 100);
        $display("timeout, the test sequence did not complete");
        $display("tests failed");
        $finish;
    end

    initial begin
        i_rst_n = 1'b0;
        arch[0] = '0;
        rf[0] = '0;
        for (int k = 1; k < 32; k++) begin
            arch[k] = next_rand();
            rf[k] = arch[k];
        end
        // a live instruction sits on the inputs through reset
        drive_instr(alu_instr(mips_ex_pkg::I_TYPE, 6'h0d, 5'd1, 5'd2, 5'd3, 1'b1), 1'b0);
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
        reset_values();
        alu_results();
        forwarding_paths();
        load_store_lanes();
        halt_hold();
        repeat (2) step(bubble(), 1'b0);
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== hw/execute_subsystem.sv ====
module execute_subsystem (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_halt,
    input  mips_ex_pkg::reg_idx_t i_rs,
    input  mips_ex_pkg::reg_idx_t i_rt,
    input  mips_ex_pkg::reg_idx_t i_rd,
    input  mips_ex_pkg::data_t    i_reg_da,
    input  mips_ex_pkg::data_t    i_reg_db,
    input  mips_ex_pkg::data_t    i_immediate,
    input  logic [5:0]            i_opcode,
    input  logic [4:0]            i_shamt,
    input  logic [5:0]            i_func,
    input  mips_ex_pkg::ex_ctrl_t i_ctrl,
    output mips_ex_pkg::mem_wb_t  o_mem_wb
);

    mips_ex_pkg::ex_mem_t  ex_mem;
    mips_ex_pkg::fwd_sel_e fw_a;
    mips_ex_pkg::fwd_sel_e fw_b;

    instruction_execute u_execute (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_halt         (i_halt),
        .i_rs           (i_rs),
        .i_rt           (i_rt),
        .i_rd           (i_rd),
        .i_reg_da       (i_reg_da),
        .i_reg_db       (i_reg_db),
        .i_immediate    (i_immediate),
        .i_opcode       (i_opcode),
        .i_func         (i_func),
        .i_shamt        (i_shamt),
        .i_ctrl         (i_ctrl),
        .i_fw_a         (fw_a),
        .i_fw_b         (fw_b),
        .i_exmem_result (ex_mem.result),
        .i_memwb_data   (o_mem_wb.wb_data),
        .o_ex_mem       (ex_mem)
    );

    memory_access u_memory (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_halt   (i_halt),
        .i_ex_mem (ex_mem),
        .o_mem_wb (o_mem_wb)
    );

    forwarding_unit u_forward (
        .i_rs              (i_rs),
        .i_rt              (i_rt),
        .i_exmem_reg_write (ex_mem.reg_write),
        .i_memwb_reg_write (o_mem_wb.reg_write),
        .i_exmem_rd        (ex_mem.write_reg),
        .i_memwb_rd        (o_mem_wb.write_reg),
        .o_fw_a            (fw_a),
        .o_fw_b            (fw_b)
    );

endmodule

// ==== hw/memory_access.sv ====
`include "mips_ex_settings.svh"

module memory_access (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_halt,
    input  mips_ex_pkg::ex_mem_t i_ex_mem,
    output mips_ex_pkg::mem_wb_t o_mem_wb
);

    localparam int IDX_W = $clog2(`MIPS_DMEM_WORDS);

    mips_ex_pkg::data_t   dmem [`MIPS_DMEM_WORDS];

    logic [IDX_W-1:0]     word_idx;
    logic [1:0]           lane;
    mips_ex_pkg::data_t   rd_word;
    mips_ex_pkg::data_t   merged;
    logic [7:0]           byte_val;
    logic [15:0]          half_val;
    mips_ex_pkg::data_t   load_val;
    mips_ex_pkg::mem_wb_t mem_wb_d;

    assign word_idx = i_ex_mem.result[IDX_W+1:2];
    assign lane     = i_ex_mem.result[1:0];
    assign rd_word  = dmem[word_idx];

    // merge sub-word stores into the current word, little-endian lanes
    always_comb begin
        merged = rd_word;
        case (i_ex_mem.width)
            mips_ex_pkg::BYTE: merged[{lane, 3'b000} +: 8]   = i_ex_mem.store_data[7:0];
            mips_ex_pkg::HALF: merged[{lane[1], 4'b0000} +: 16] = i_ex_mem.store_data[15:0];
            default:           merged = i_ex_mem.store_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_ex_mem.mem_write && !i_halt) begin
            dmem[word_idx] <= merged;
        end
    end

    // load lane and extension
    always_comb begin
        byte_val = rd_word[{lane, 3'b000} +: 8];
        half_val = rd_word[{lane[1], 4'b0000} +: 16];
        case (i_ex_mem.width)
            mips_ex_pkg::BYTE: begin
                load_val = i_ex_mem.sign_ext ? {{24{byte_val[7]}}, byte_val}
                                             : {24'h000000, byte_val};
            end
            mips_ex_pkg::HALF: begin
                load_val = i_ex_mem.sign_ext ? {{16{half_val[15]}}, half_val}
                                             : {16'h0000, half_val};
            end
            default: begin
                load_val = rd_word;
            end
        endcase
        if (!i_ex_mem.mem_read) begin
            load_val = '0;
        end
    end

    always_comb begin
        mem_wb_d.reg_write = i_ex_mem.reg_write;
        mem_wb_d.write_reg = i_ex_mem.write_reg;
        mem_wb_d.wb_data   = i_ex_mem.mem_to_reg ? load_val : i_ex_mem.result;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wb <= '0;
        end else if (!i_halt) begin
            o_mem_wb <= mem_wb_d;
        end
    end

endmodule

// ==== hw/instruction_execute.sv ====
module instruction_execute (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_halt,

    input  mips_ex_pkg::reg_idx_t i_rs,
    input  mips_ex_pkg::reg_idx_t i_rt,
    input  mips_ex_pkg::reg_idx_t i_rd,

    input  mips_ex_pkg::data_t    i_reg_da,
    input  mips_ex_pkg::data_t    i_reg_db,
    input  mips_ex_pkg::data_t    i_immediate,

    input  logic [5:0]            i_opcode,
    input  logic [5:0]            i_func,
    input  logic [4:0]            i_shamt,

    input  mips_ex_pkg::ex_ctrl_t i_ctrl,

    input  mips_ex_pkg::fwd_sel_e i_fw_a,
    input  mips_ex_pkg::fwd_sel_e i_fw_b,
    input  mips_ex_pkg::data_t    i_exmem_result,
    input  mips_ex_pkg::data_t    i_memwb_data,

    output mips_ex_pkg::ex_mem_t  o_ex_mem
);

    mips_ex_pkg::alu_op_e alu_op;
    mips_ex_pkg::data_t   opnd_a;
    mips_ex_pkg::data_t   fwd_b;
    mips_ex_pkg::data_t   opnd_b;
    mips_ex_pkg::data_t   alu_result;
    mips_ex_pkg::ex_mem_t ex_mem_d;

    // alu control
    always_comb begin
        alu_op = mips_ex_pkg::NOP;
        case (i_ctrl.alu_class)
            mips_ex_pkg::LOAD_STORE: begin
                // address generation
                alu_op = mips_ex_pkg::ADD;
            end
            mips_ex_pkg::R_TYPE: begin
                case (i_func)
                    6'h20: alu_op = mips_ex_pkg::ADD;
                    6'h22: alu_op = mips_ex_pkg::SUB;
                    6'h24: alu_op = mips_ex_pkg::AND;
                    6'h25: alu_op = mips_ex_pkg::OR;
                    6'h26: alu_op = mips_ex_pkg::XOR;
                    6'h27: alu_op = mips_ex_pkg::NOR;
                    6'h2a: alu_op = mips_ex_pkg::SLT;
                    6'h00: alu_op = mips_ex_pkg::SLL;
                    6'h02: alu_op = mips_ex_pkg::SRL;
                    6'h03: alu_op = mips_ex_pkg::SRA;
                    default: alu_op = mips_ex_pkg::NOP;
                endcase
            end
            mips_ex_pkg::I_TYPE: begin
                case (i_opcode)
                    6'h08: alu_op = mips_ex_pkg::ADD;
                    6'h0c: alu_op = mips_ex_pkg::AND;
                    6'h0d: alu_op = mips_ex_pkg::OR;
                    6'h0e: alu_op = mips_ex_pkg::XOR;
                    6'h0a: alu_op = mips_ex_pkg::SLT;
                    6'h0f: alu_op = mips_ex_pkg::LUI;
                    default: alu_op = mips_ex_pkg::NOP;
                endcase
            end
            default: begin
                // branch, alu idles
                alu_op = mips_ex_pkg::NOP;
            end
        endcase
    end

    // operand muxes
    always_comb begin
        case (i_fw_a)
            mips_ex_pkg::EXMEM: opnd_a = i_exmem_result;
            mips_ex_pkg::MEMWB: opnd_a = i_memwb_data;
            default:            opnd_a = i_reg_da;
        endcase

        case (i_fw_b)
            mips_ex_pkg::EXMEM: fwd_b = i_exmem_result;
            mips_ex_pkg::MEMWB: fwd_b = i_memwb_data;
            default:            fwd_b = i_reg_db;
        endcase

        opnd_b = i_ctrl.imm_sel ? i_immediate : fwd_b;
    end

    alu u_alu (
        .i_op     (alu_op),
        .i_a      (opnd_a),
        .i_b      (opnd_b),
        .i_shamt  (i_shamt),
        .o_result (alu_result)
    );

    always_comb begin
        ex_mem_d.mem_to_reg = i_ctrl.mem_to_reg;
        ex_mem_d.mem_read   = i_ctrl.mem_read;
        ex_mem_d.mem_write  = i_ctrl.mem_write;
        ex_mem_d.reg_write  = i_ctrl.reg_write;
        ex_mem_d.width      = i_ctrl.width;
        ex_mem_d.sign_ext   = i_ctrl.sign_ext;
        // rd for r-type, rt for immediates and loads
        ex_mem_d.write_reg  = i_ctrl.reg_dst ? i_rd : i_rt;
        ex_mem_d.result     = alu_result;
        // store data is taken before the immediate mux
        ex_mem_d.store_data = fwd_b;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem       <= '0;
            o_ex_mem.width <= mips_ex_pkg::WORD;
        end else if (!i_halt) begin
            o_ex_mem <= ex_mem_d;
        end
    end

endmodule

// ==== hw/forwarding_unit.sv ====
module forwarding_unit (
    input  mips_ex_pkg::reg_idx_t i_rs,
    input  mips_ex_pkg::reg_idx_t i_rt,
    input  logic                  i_exmem_reg_write,
    input  logic                  i_memwb_reg_write,
    input  mips_ex_pkg::reg_idx_t i_exmem_rd,
    input  mips_ex_pkg::reg_idx_t i_memwb_rd,
    output mips_ex_pkg::fwd_sel_e o_fw_a,
    output mips_ex_pkg::fwd_sel_e o_fw_b
);

    // newer result in ex/mem wins over mem/wb
    function automatic mips_ex_pkg::fwd_sel_e pick_source(
        input mips_ex_pkg::reg_idx_t src
    );
        mips_ex_pkg::fwd_sel_e sel;
        sel = mips_ex_pkg::REG;
        if (src != '0) begin
            if (i_exmem_reg_write && (i_exmem_rd == src)) begin
                sel = mips_ex_pkg::EXMEM;
            end else if (i_memwb_reg_write && (i_memwb_rd == src)) begin
                sel = mips_ex_pkg::MEMWB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        o_fw_a = pick_source(i_rs);
        o_fw_b = pick_source(i_rt);
    end

endmodule

// ==== hw/alu.sv ====
module alu (
    input  mips_ex_pkg::alu_op_e i_op,
    input  mips_ex_pkg::data_t   i_a,
    input  mips_ex_pkg::data_t   i_b,
    input  logic [4:0]           i_shamt,
    output mips_ex_pkg::data_t   o_result
);

    always_comb begin
        o_result = '0;
        case (i_op)
            mips_ex_pkg::ADD: begin
                o_result = i_a + i_b;
            end
            mips_ex_pkg::SUB: begin
                o_result = i_a - i_b;
            end
            mips_ex_pkg::AND: begin
                o_result = i_a & i_b;
            end
            mips_ex_pkg::OR: begin
                o_result = i_a | i_b;
            end
            mips_ex_pkg::XOR: begin
                o_result = i_a ^ i_b;
            end
            mips_ex_pkg::NOR: begin
                o_result = ~(i_a | i_b);
            end
            mips_ex_pkg::SLT: begin
                // signed compare, result is 0 or 1
                o_result[0] = $signed(i_a) < $signed(i_b);
            end
            mips_ex_pkg::SLL: begin
                o_result = i_b << i_shamt;
            end
            mips_ex_pkg::SRL: begin
                o_result = i_b >> i_shamt;
            end
            mips_ex_pkg::SRA: begin
                o_result = $signed(i_b) >>> i_shamt;
            end
            mips_ex_pkg::LUI: begin
                o_result = {i_b[15:0], 16'h0000};
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

// ==== hw/mips_ex_pkg.sv ====
`include "mips_ex_settings.svh"

package mips_ex_pkg;

    typedef logic [`MIPS_DATA_W-1:0] data_t;
    typedef logic [`MIPS_REG_W-1:0]  reg_idx_t;

    // coarse op grouping from the control unit
    typedef enum logic [1:0] {
        LOAD_STORE = 2'b00,
        BRANCH     = 2'b01,
        R_TYPE     = 2'b10,
        I_TYPE     = 2'b11
    } alu_class_e;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        NOR = 4'd5,
        SLT = 4'd6,
        SLL = 4'd7,
        SRL = 4'd8,
        SRA = 4'd9,
        LUI = 4'd10,
        NOP = 4'd15
    } alu_op_e;

    typedef enum logic [1:0] {
        REG   = 2'b00,
        MEMWB = 2'b10,
        EXMEM = 2'b11
    } fwd_sel_e;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b11
    } mem_width_e;

    typedef struct packed {
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        logic       reg_dst;
        logic       imm_sel;
        mem_width_e width;
        logic       sign_ext;
        alu_class_e alu_class;
    } ex_ctrl_t;

    typedef struct packed {
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic       reg_write;
        mem_width_e width;
        logic       sign_ext;
        reg_idx_t   write_reg;
        data_t      result;
        data_t      store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t write_reg;
        data_t    wb_data;
    } mem_wb_t;

endpackage

// ==== hw/mips_ex_settings.svh ====
`ifndef MIPS_EX_SETTINGS_SVH
`define MIPS_EX_SETTINGS_SVH

// machine word
`define MIPS_DATA_W 32

// register number
`define MIPS_REG_W 5

// data memory depth in 32-bit words
`define MIPS_DMEM_WORDS 64

`endif
